/* rtl/CpuPkg.sv */
package CpuPkg;

  // datapath and address width
  localparam int xlen = 32;

  // 32 architectural registers
  localparam int regIndexWidth = 5;

  // major opcodes, RV32I encodings
  typedef enum logic [6:0] {
    opRegReg = 7'b0110011,
    opImm    = 7'b0010011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011
  } opcode_e;

  // operations the ALU can perform
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluXor = 3'd4,
    aluSlt = 3'd5
  } aluOp_e;

  // where an ALU operand comes from
  typedef enum logic [1:0] {
    fwdRegister  = 2'b00,
    fwdWriteback = 2'b01,
    fwdMemory    = 2'b10
  } forwardSel_e;

endpackage

/* rtl/PipelineBuses.sv */
`timescale 1ns/1ps

// decode to execute pipeline register contents
interface idExBus;
  logic [CpuPkg::xlen-1:0] lhsValue;
  logic [CpuPkg::xlen-1:0] rhsValue;
  logic [CpuPkg::xlen-1:0] immediate;
  logic [CpuPkg::regIndexWidth-1:0] lhsIndex;
  logic [CpuPkg::regIndexWidth-1:0] rhsIndex;
  logic [CpuPkg::regIndexWidth-1:0] writeIndex;
  CpuPkg::aluOp_e aluOp;
  logic aluSrc;
  logic memWrite;
  logic memToReg;
  logic regWrite;

  modport decode(
    output lhsValue, rhsValue, immediate, lhsIndex, rhsIndex, writeIndex,
    output aluOp, aluSrc, memWrite, memToReg, regWrite
  );
  modport execute(
    input lhsValue, rhsValue, immediate, lhsIndex, rhsIndex, writeIndex,
    input aluOp, aluSrc, memWrite, memToReg, regWrite
  );
endinterface

// execute to memory pipeline register contents
interface exMemBus;
  logic [CpuPkg::xlen-1:0] aluResult;
  logic [CpuPkg::xlen-1:0] storeData;
  logic [CpuPkg::regIndexWidth-1:0] writeIndex;
  logic memWrite;
  logic memToReg;
  logic regWrite;

  // the execute stage also reads its own outputs back for forwarding
  modport execute(output aluResult, storeData, writeIndex, memWrite, memToReg, regWrite);
  modport memory(input aluResult, storeData, writeIndex, memWrite, memToReg, regWrite);
endinterface

// memory to writeback pipeline register contents
interface memWbBus;
  logic [CpuPkg::xlen-1:0] memoryData;
  logic [CpuPkg::xlen-1:0] executionData;
  logic [CpuPkg::regIndexWidth-1:0] writeIndex;
  logic memToReg;
  logic regWrite;

  modport memory(output memoryData, executionData, writeIndex, memToReg, regWrite);
  modport writeback(input memoryData, executionData, writeIndex, memToReg, regWrite);
  modport forward(input writeIndex, regWrite);
endinterface

/* rtl/InstructionFetch.sv */
`timescale 1ns/1ps

module InstructionFetch #(
  parameter int imemDepth = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          imemWrite,
  input  logic [$clog2(imemDepth)-1:0]  imemAddr,
  input  logic [CpuPkg::xlen-1:0]       imemData,
  output logic [CpuPkg::xlen-1:0]       pc,
  output logic [CpuPkg::xlen-1:0]       instruction
);
  localparam int addrBits = $clog2(imemDepth);

  logic [CpuPkg::xlen-1:0] instructionMemory [imemDepth];

  // program load, only accepted while held in reset
  always_ff @(posedge clk) begin
    if (reset && imemWrite) begin
      instructionMemory[imemAddr] <= imemData;
    end
  end

  // no branches, so pc only counts up
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // fetch to decode register, zero is a no-op
  always_ff @(posedge clk) begin
    if (reset) begin
      instruction <= '0;
    end else begin
      instruction <= instructionMemory[pc[addrBits+1:2]];
    end
  end

endmodule

/* rtl/RegisterFile.sv */
`timescale 1ns/1ps

module RegisterFile (
  input  logic                               clk,
  input  logic [CpuPkg::regIndexWidth-1:0]   readIndex1,
  input  logic [CpuPkg::regIndexWidth-1:0]   readIndex2,
  input  logic [CpuPkg::regIndexWidth-1:0]   writeIndex,
  input  logic [CpuPkg::xlen-1:0]            writeData,
  input  logic                               shouldWrite,
  input  logic [CpuPkg::regIndexWidth-1:0]   debugIndex,
  output logic [CpuPkg::xlen-1:0]            readData1,
  output logic [CpuPkg::xlen-1:0]            readData2,
  output logic [CpuPkg::xlen-1:0]            debugData
);
  logic [CpuPkg::xlen-1:0] registers [1 << CpuPkg::regIndexWidth];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (shouldWrite && writeIndex != '0) begin
      registers[writeIndex] <= writeData;
    end
  end

  // same-cycle write is bypassed to the readers
  assign readData1 = (readIndex1 == '0) ? '0 :
                     (shouldWrite && readIndex1 == writeIndex) ? writeData :
                     registers[readIndex1];
  assign readData2 = (readIndex2 == '0) ? '0 :
                     (shouldWrite && readIndex2 == writeIndex) ? writeData :
                     registers[readIndex2];

  // debug port shows committed state only
  assign debugData = (debugIndex == '0) ? '0 : registers[debugIndex];

endmodule

/* rtl/DecodeStage.sv */
`timescale 1ns/1ps

module DecodeStage (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [CpuPkg::xlen-1:0]            instruction,
  idExBus.decode                             idEx,
  memWbBus.writeback                         memWb,
  input  logic [CpuPkg::regIndexWidth-1:0]   debugRegIndex,
  output logic [CpuPkg::xlen-1:0]            debugRegData,
  output logic [CpuPkg::xlen-1:0]            writeBackData
);
  CpuPkg::opcode_e opcode;
  CpuPkg::aluOp_e aluOp;
  logic [2:0] funct3;
  logic [CpuPkg::xlen-1:0] immediate;
  logic [CpuPkg::xlen-1:0] lhsValue;
  logic [CpuPkg::xlen-1:0] rhsValue;
  logic aluSupported;
  logic aluSrc;
  logic memWrite;
  logic memToReg;
  logic regWrite;

  assign opcode = CpuPkg::opcode_e'(instruction[6:0]);
  assign funct3 = instruction[14:12];

  // only ADD/SUB, SLT, XOR, OR and AND encodings
  assign aluSupported = (funct3 == 3'b000) || (funct3 == 3'b010) ||
                        (funct3 == 3'b100) || (funct3 == 3'b110) || (funct3 == 3'b111);

  always_comb begin
    aluOp = CpuPkg::aluAdd;
    aluSrc = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    immediate = {{(CpuPkg::xlen-12){instruction[31]}}, instruction[31:20]};
    case (funct3)
      3'b010:  aluOp = CpuPkg::aluSlt;
      3'b100:  aluOp = CpuPkg::aluXor;
      3'b110:  aluOp = CpuPkg::aluOr;
      3'b111:  aluOp = CpuPkg::aluAnd;
      default: aluOp = CpuPkg::aluAdd;
    endcase
    case (opcode)
      CpuPkg::opRegReg: begin
        // funct7 bit 30 selects SUB, register-register only
        if (funct3 == 3'b000 && instruction[30]) begin
          aluOp = CpuPkg::aluSub;
        end
        regWrite = aluSupported;
      end
      CpuPkg::opImm: begin
        aluSrc = 1'b1;
        regWrite = aluSupported;
      end
      CpuPkg::opLoad: begin
        aluOp = CpuPkg::aluAdd;
        aluSrc = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      CpuPkg::opStore: begin
        aluOp = CpuPkg::aluAdd;
        aluSrc = 1'b1;
        memWrite = 1'b1;
        immediate = {{(CpuPkg::xlen-12){instruction[31]}}, instruction[31:25],
                     instruction[11:7]};
      end
      // anything else behaves as a no-op
      default: ;
    endcase
  end

  // writeback mux
  assign writeBackData = memWb.memToReg ? memWb.memoryData : memWb.executionData;

  RegisterFile registerFile(
    .clk(clk),
    .readIndex1(instruction[19:15]),
    .readIndex2(instruction[24:20]),
    .writeIndex(memWb.writeIndex),
    .writeData(writeBackData),
    .shouldWrite(memWb.regWrite),
    .debugIndex(debugRegIndex),
    .readData1(lhsValue),
    .readData2(rhsValue),
    .debugData(debugRegData)
  );

  always_ff @(posedge clk) begin
    idEx.lhsValue <= lhsValue;
    idEx.rhsValue <= rhsValue;
    idEx.immediate <= immediate;
    idEx.lhsIndex <= instruction[19:15];
    idEx.rhsIndex <= instruction[24:20];
    idEx.writeIndex <= instruction[11:7];
    idEx.aluOp <= aluOp;
    idEx.aluSrc <= aluSrc;
    idEx.memToReg <= memToReg;
    if (reset) begin
      idEx.regWrite <= 1'b0;
      idEx.memWrite <= 1'b0;
    end else begin
      idEx.regWrite <= regWrite;
      idEx.memWrite <= memWrite;
    end
  end

endmodule

/* rtl/ForwardingUnit.sv */
`timescale 1ns/1ps

module ForwardingUnit (
  input  logic [CpuPkg::regIndexWidth-1:0] readIndex,
  input  logic [CpuPkg::regIndexWidth-1:0] memoryWriteIndex,
  input  logic [CpuPkg::regIndexWidth-1:0] writebackWriteIndex,
  input  logic                             isMemoryWrite,
  input  logic                             isWritebackWrite,
  output CpuPkg::forwardSel_e              forwardSelect
);
  logic memoryMatch;
  logic writebackMatch;

  // x0 never forwards, it always reads zero
  assign memoryMatch = isMemoryWrite && (memoryWriteIndex != '0) &&
                       (memoryWriteIndex == readIndex);
  assign writebackMatch = isWritebackWrite && (writebackWriteIndex != '0) &&
                          (writebackWriteIndex == readIndex);

  // the younger result in memory takes priority
  always_comb begin
    if (memoryMatch) begin
      forwardSelect = CpuPkg::fwdMemory;
    end else if (writebackMatch) begin
      forwardSelect = CpuPkg::fwdWriteback;
    end else begin
      forwardSelect = CpuPkg::fwdRegister;
    end
  end

endmodule

/* rtl/ExecuteStage.sv */
`timescale 1ns/1ps

module ExecuteStage (
  input  logic                    clk,
  input  logic                    reset,
  idExBus.execute                 idEx,
  exMemBus.execute                exMem,
  memWbBus.forward                memWb,
  input  logic [CpuPkg::xlen-1:0] writeBackData
);
  CpuPkg::forwardSel_e lhsSelect;
  CpuPkg::forwardSel_e rhsSelect;
  logic [CpuPkg::xlen-1:0] lhsOperand;
  logic [CpuPkg::xlen-1:0] rhsForwarded;
  logic [CpuPkg::xlen-1:0] rhsOperand;
  logic [CpuPkg::xlen-1:0] aluResult;

  ForwardingUnit lhsForwarding(
    .readIndex(idEx.lhsIndex),
    .memoryWriteIndex(exMem.writeIndex),
    .writebackWriteIndex(memWb.writeIndex),
    .isMemoryWrite(exMem.regWrite),
    .isWritebackWrite(memWb.regWrite),
    .forwardSelect(lhsSelect)
  );

  ForwardingUnit rhsForwarding(
    .readIndex(idEx.rhsIndex),
    .memoryWriteIndex(exMem.writeIndex),
    .writebackWriteIndex(memWb.writeIndex),
    .isMemoryWrite(exMem.regWrite),
    .isWritebackWrite(memWb.regWrite),
    .forwardSelect(rhsSelect)
  );

  always_comb begin
    case (lhsSelect)
      CpuPkg::fwdMemory:    lhsOperand = exMem.aluResult;
      CpuPkg::fwdWriteback: lhsOperand = writeBackData;
      default:              lhsOperand = idEx.lhsValue;
    endcase
    case (rhsSelect)
      CpuPkg::fwdMemory:    rhsForwarded = exMem.aluResult;
      CpuPkg::fwdWriteback: rhsForwarded = writeBackData;
      default:              rhsForwarded = idEx.rhsValue;
    endcase
  end

  // immediate replaces rs2 for ALU-immediate, load and store
  assign rhsOperand = idEx.aluSrc ? idEx.immediate : rhsForwarded;

  always_comb begin
    case (idEx.aluOp)
      CpuPkg::aluAdd: aluResult = lhsOperand + rhsOperand;
      CpuPkg::aluSub: aluResult = lhsOperand - rhsOperand;
      CpuPkg::aluAnd: aluResult = lhsOperand & rhsOperand;
      CpuPkg::aluOr:  aluResult = lhsOperand | rhsOperand;
      CpuPkg::aluXor: aluResult = lhsOperand ^ rhsOperand;
      CpuPkg::aluSlt: aluResult = {{(CpuPkg::xlen-1){1'b0}},
                                   $signed(lhsOperand) < $signed(rhsOperand)};
      default:        aluResult = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    exMem.aluResult <= aluResult;
    // store data is the forwarded rs2, not the immediate
    exMem.storeData <= rhsForwarded;
    exMem.writeIndex <= idEx.writeIndex;
    exMem.memToReg <= idEx.memToReg;
    if (reset) begin
      exMem.regWrite <= 1'b0;
      exMem.memWrite <= 1'b0;
    end else begin
      exMem.regWrite <= idEx.regWrite;
      exMem.memWrite <= idEx.memWrite;
    end
  end

endmodule

/* rtl/MemoryStage.sv */
`timescale 1ns/1ps

module MemoryStage #(
  parameter int dmemDepth = 64
) (
  input  logic clk,
  input  logic reset,
  exMemBus.memory exMem,
  memWbBus.memory memWb
);
  localparam int addrBits = $clog2(dmemDepth);

  logic [CpuPkg::xlen-1:0] dataMemory [dmemDepth];
  logic [addrBits-1:0] wordAddress;
  logic [CpuPkg::xlen-1:0] readData;

  // word accesses only, low address bits dropped
  assign wordAddress = exMem.aluResult[addrBits+1:2];
  assign readData = dataMemory[wordAddress];

  always_ff @(posedge clk) begin
    if (exMem.memWrite) begin
      dataMemory[wordAddress] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk) begin
    memWb.memoryData <= readData;
    memWb.executionData <= exMem.aluResult;
    memWb.writeIndex <= exMem.writeIndex;
    memWb.memToReg <= exMem.memToReg;
    if (reset) begin
      memWb.regWrite <= 1'b0;
    end else begin
      memWb.regWrite <= exMem.regWrite;
    end
  end

endmodule

/* rtl/CPU.sv */
`timescale 1ns/1ps

module CPU #(
  parameter int imemDepth = 64,
  parameter int dmemDepth = 64
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               imemWrite,
  input  logic [$clog2(imemDepth)-1:0]       imemAddr,
  input  logic [CpuPkg::xlen-1:0]            imemData,
  input  logic [CpuPkg::regIndexWidth-1:0]   debugRegIndex,
  output logic [CpuPkg::xlen-1:0]            debugRegData,
  output logic [CpuPkg::xlen-1:0]            fetchPc
);
  logic [CpuPkg::xlen-1:0] instruction;
  logic [CpuPkg::xlen-1:0] writeBackData;

  idExBus idEx();
  exMemBus exMem();
  memWbBus memWb();

  InstructionFetch #(.imemDepth(imemDepth)) instructionFetch(
    .clk(clk),
    .reset(reset),
    .imemWrite(imemWrite),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .pc(fetchPc),
    .instruction(instruction)
  );

  DecodeStage decodeStage(
    .clk(clk),
    .reset(reset),
    .instruction(instruction),
    .idEx(idEx.decode),
    .memWb(memWb.writeback),
    .debugRegIndex(debugRegIndex),
    .debugRegData(debugRegData),
    .writeBackData(writeBackData)
  );

  // writeback value comes back from decode for forwarding
  ExecuteStage executeStage(
    .clk(clk),
    .reset(reset),
    .idEx(idEx.execute),
    .exMem(exMem.execute),
    .memWb(memWb.forward),
    .writeBackData(writeBackData)
  );

  MemoryStage #(.dmemDepth(dmemDepth)) memoryStage(
    .clk(clk),
    .reset(reset),
    .exMem(exMem.memory),
    .memWb(memWb.memory)
  );

endmodule

/* tests/forwarding_props.sv */
`timescale 1ns/1ps

module ForwardingProps (
  input logic                    clk,
  input logic                    reset,
  input logic [CpuPkg::xlen-1:0] fetchPc,
  input logic [4:0]              memoryWriteIndex,
  input logic [1:0]              lhsSelect,
  input logic [1:0]              rhsSelect,
  input logic                    idExRegWrite,
  input logic                    idExMemWrite,
  input logic                    exMemRegWrite,
  input logic                    exMemMemWrite,
  input logic                    memWbRegWrite
);

  // x0 in the memory stage never forwards
  noForwardFromZero: assert property (@(posedge clk) disable iff (reset)
    memoryWriteIndex == 5'd0 |->
      (lhsSelect != CpuPkg::fwdMemory && rhsSelect != CpuPkg::fwdMemory))
    else $error("memory forwarding selected with write index zero");

  // all write enables cleared by reset
  controlClearedAfterReset: assert property (@(posedge clk)
    reset |=>
      !(idExRegWrite || idExMemWrite || exMemRegWrite || exMemMemWrite || memWbRegWrite))
    else $error("write enable set in the cycle after a reset cycle");

  pcAdvances: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> fetchPc == $past(fetchPc) + 32'd4)
    else $error("fetch pc did not advance by 4");

endmodule

bind CPU ForwardingProps forwardingProps (
  .clk(clk),
  .reset(reset),
  .fetchPc(fetchPc),
  .memoryWriteIndex(exMem.writeIndex),
  .lhsSelect(executeStage.lhsSelect),
  .rhsSelect(executeStage.rhsSelect),
  .idExRegWrite(idEx.regWrite),
  .idExMemWrite(idEx.memWrite),
  .exMemRegWrite(exMem.regWrite),
  .exMemMemWrite(exMem.memWrite),
  .memWbRegWrite(memWb.regWrite)
);

/* tests/CpuTb.sv */
`timescale 1ns/1ps

module CpuTb;
  localparam int imemDepth = 128;
  localparam int dmemDepth = 64;
  localparam int imemAddrBits = $clog2(imemDepth);
  localparam int numRows = 35;
  localparam logic [31:0] endPc = (numRows + 5) * 4;
  localparam int runTimeout = 200;

  typedef enum logic [3:0] {
    instAdd, instSub, instAnd, instOr, instXor, instSlt,
    instAddi, instAndi, instOri, instXori, instSlti, instLw, instSw, instBad
  } mnemonic_e;

  typedef struct packed {
    mnemonic_e op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
  } programRow_t;

  logic clk;
  logic reset;
  logic imemWrite;
  logic [imemAddrBits-1:0] imemAddr;
  logic [31:0] imemData;
  logic [4:0] debugRegIndex;
  logic [31:0] debugRegData;
  logic [31:0] fetchPc;
  logic [31:0] modelRegs [32];
  logic [31:0] modelData [dmemDepth];

  // op, rd, rs1, rs2, imm
  programRow_t programTable [numRows] = '{
    '{instAddi, 5'd1, 5'd0, 5'd0, 12'h005}, '{instAddi, 5'd2, 5'd0, 5'd0, 12'hffd},
    '{instOri, 5'd3, 5'd0, 5'd0, 12'h0f0}, '{instXori, 5'd4, 5'd0, 5'd0, 12'hfff},
    '{instAndi, 5'd5, 5'd4, 5'd0, 12'h7f0}, '{instSlti, 5'd6, 5'd0, 5'd0, 12'hfff},
    '{instSlti, 5'd7, 5'd2, 5'd0, 12'hfff},
    // back-to-back chains through memory and writeback forwarding
    '{instAdd, 5'd8, 5'd1, 5'd2, 12'h000}, '{instSub, 5'd9, 5'd8, 5'd1, 12'h000},
    '{instAnd, 5'd10, 5'd8, 5'd4, 12'h000}, '{instOr, 5'd11, 5'd9, 5'd10, 12'h000},
    '{instXor, 5'd12, 5'd11, 5'd3, 12'h000}, '{instSlt, 5'd13, 5'd12, 5'd11, 12'h000},
    '{instSlt, 5'd14, 5'd1, 5'd9, 12'h000}, '{instSub, 5'd15, 5'd13, 5'd14, 12'h000},
    // x16 reaches row 18 through the register file bypass
    '{instAddi, 5'd16, 5'd0, 5'd0, 12'h064}, '{instAddi, 5'd17, 5'd0, 5'd0, 12'h007},
    '{instAddi, 5'd18, 5'd0, 5'd0, 12'h009}, '{instAdd, 5'd19, 5'd16, 5'd17, 12'h000},
    // store, load back, use two later
    '{instAddi, 5'd20, 5'd0, 5'd0, 12'h040}, '{instSw, 5'd0, 5'd20, 5'd19, 12'h008},
    '{instLw, 5'd21, 5'd20, 5'd0, 12'h008}, '{instAddi, 5'd22, 5'd0, 5'd0, 12'h001},
    '{instAdd, 5'd23, 5'd21, 5'd22, 12'h000}, '{instSw, 5'd0, 5'd20, 5'd1, 12'h000},
    // x0 writes and reads
    '{instAddi, 5'd0, 5'd0, 5'd0, 12'h037}, '{instAdd, 5'd24, 5'd0, 5'd0, 12'h000},
    '{instOr, 5'd25, 5'd1, 5'd0, 12'h000},
    // looks like a store to word 16 with rd x1 if misdecoded
    '{instBad, 5'd0, 5'd20, 5'd9, 12'h001}, '{instLw, 5'd26, 5'd20, 5'd0, 12'h000},
    '{instAddi, 5'd27, 5'd0, 5'd0, 12'h123}, '{instAddi, 5'd28, 5'd0, 5'd0, 12'h800},
    '{instAdd, 5'd29, 5'd26, 5'd27, 12'h000}, '{instSlti, 5'd30, 5'd28, 5'd0, 12'hfff},
    '{instAndi, 5'd31, 5'd12, 5'd0, 12'h0ff}
  };

  CPU #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) i_CPU (
    .clk(clk),
    .reset(reset),
    .imemWrite(imemWrite),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .debugRegIndex(debugRegIndex),
    .debugRegData(debugRegData),
    .fetchPc(fetchPc)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] encodeR(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input programRow_t row);
    return {funct7, row.rs2, row.rs1, funct3, row.rd, CpuPkg::opRegReg};
  endfunction

  function automatic logic [31:0] encodeI(input CpuPkg::opcode_e opcode,
                                          input logic [2:0] funct3, input programRow_t row);
    return {row.imm, row.rs1, funct3, row.rd, opcode};
  endfunction

  function automatic logic [31:0] encodeS(input logic [6:0] opcode, input logic [2:0] funct3,
                                          input programRow_t row);
    return {row.imm[11:5], row.rs2, row.rs1, funct3, row.imm[4:0], opcode};
  endfunction

  function automatic logic [31:0] encodeRow(input programRow_t row);
    case (row.op)
      instAdd:  return encodeR(7'h00, 3'd0, row);
      instSub:  return encodeR(7'h20, 3'd0, row);
      instAnd:  return encodeR(7'h00, 3'd7, row);
      instOr:   return encodeR(7'h00, 3'd6, row);
      instXor:  return encodeR(7'h00, 3'd4, row);
      instSlt:  return encodeR(7'h00, 3'd2, row);
      instAddi: return encodeI(CpuPkg::opImm, 3'd0, row);
      instAndi: return encodeI(CpuPkg::opImm, 3'd7, row);
      instOri:  return encodeI(CpuPkg::opImm, 3'd6, row);
      instXori: return encodeI(CpuPkg::opImm, 3'd4, row);
      instSlti: return encodeI(CpuPkg::opImm, 3'd2, row);
      instLw:   return encodeI(CpuPkg::opLoad, 3'd2, row);
      instSw:   return encodeS(CpuPkg::opStore, 3'd2, row);
      // opcode outside the supported set
      default:  return encodeS(7'b0100111, 3'd2, row);
    endcase
  endfunction

  // in-order ISA execution of the table
  task automatic runModel();
    programRow_t row;
    logic [31:0] lhs, rhs, imm, addr, result;
    logic writesReg;
    for (int r = 0; r < 32; r++) begin
      modelRegs[r[4:0]] = '0;
    end
    for (int i = 0; i < numRows; i++) begin
      row = programTable[i[5:0]];
      lhs = modelRegs[row.rs1];
      rhs = modelRegs[row.rs2];
      imm = {{20{row.imm[11]}}, row.imm};
      addr = lhs + imm;
      writesReg = 1'b1;
      result = '0;
      case (row.op)
        instAdd:  result = lhs + rhs;
        instSub:  result = lhs - rhs;
        instAnd:  result = lhs & rhs;
        instOr:   result = lhs | rhs;
        instXor:  result = lhs ^ rhs;
        instSlt:  result = ($signed(lhs) < $signed(rhs)) ? 32'd1 : 32'd0;
        instAddi: result = lhs + imm;
        instAndi: result = lhs & imm;
        instOri:  result = lhs | imm;
        instXori: result = lhs ^ imm;
        instSlti: result = ($signed(lhs) < $signed(imm)) ? 32'd1 : 32'd0;
        instLw:   result = modelData[addr[7:2]];
        instSw: begin
          modelData[addr[7:2]] = rhs;
          writesReg = 1'b0;
        end
        default:  writesReg = 1'b0;
      endcase
      if (writesReg && row.rd != 5'd0) begin
        modelRegs[row.rd] = result;
      end
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  initial begin
    int cycles;
    reset = 1'b1;
    imemWrite = 1'b0;
    imemAddr = '0;
    imemData = '0;
    debugRegIndex = '0;
    runModel();

    // program first, then zero no-ops to the end of memory
    for (int addr = 0; addr < imemDepth; addr++) begin
      @(posedge clk);
      imemWrite <= 1'b1;
      imemAddr <= addr[imemAddrBits-1:0];
      if (addr < numRows) begin
        imemData <= encodeRow(programTable[addr[5:0]]);
      end else begin
        imemData <= 32'd0;
      end
    end
    @(posedge clk);
    imemWrite <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    cycles = 0;
    while (fetchPc <= endPc && cycles < runTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (fetchPc <= endPc) begin
      $display("Error: pipeline did not reach the end of the program in %0d cycles",
               runTimeout);
      $display("Test failed");
      $fatal(1, "run timeout");
    end
    // pc starts at zero and steps by 4 on every edge out of reset
    checkValue("fetch pc", (cycles - 1) * 4, fetchPc);

    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      debugRegIndex <= i[4:0];
      @(negedge clk);
      checkValue($sformatf("register x%0d", i), modelRegs[i[4:0]], debugRegData);
    end
    $display("Test passed");
    $finish;
  end

endmodule

/* cpu.f */
rtl/CpuPkg.sv
rtl/PipelineBuses.sv
rtl/InstructionFetch.sv
rtl/RegisterFile.sv
rtl/DecodeStage.sv
rtl/ForwardingUnit.sv
rtl/ExecuteStage.sv
rtl/MemoryStage.sv
rtl/CPU.sv
tests/forwarding_props.sv
tests/CpuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module CpuTb -f cpu.f -o simCpu
./obj_dir/simCpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
grep -q "Test passed" sim.log
